//--- verilog/video_pkg.sv
package video_pkg;

    // Beam position and raster flags, one pixel per clock
    typedef struct packed {
        logic [5:0] x;
        logic [4:0] y;
        logic       hblank;
        logic       vblank;
        logic       hsync;
        logic       vsync;
    } raster_t;

    // Pixel from one tile layer
    typedef struct packed {
        logic       opaque;
        logic [3:0] bank;
    } layer_pxl_t;

    typedef enum logic {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e     op;
        logic [11:0] addr;
        logic [15:0] wdata;
    } cpu_cmd_t;

    // Region select in addr[11:9], codes 3 to 5 read as zero
    typedef enum logic [2:0] {
        TGT_LAYER0  = 3'd0,
        TGT_LAYER1  = 3'd1,
        TGT_LAYER2  = 3'd2,
        TGT_PALETTE = 3'd6,
        TGT_MIXER   = 3'd7
    } cpu_target_e;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_ACK
    } bus_state_e;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hblank;
        logic       vblank;
        logic       hsync;
        logic       vsync;
    } video_out_t;

    // Memory sizes
    localparam int TILEMAP_DEPTH = 256;
    localparam int PATTERN_DEPTH = 128;
    localparam int PALETTE_DEPTH = 64;

    // Register words inside a layer region and the mixer region
    localparam logic [6:0] REG_HSCROLL  = 7'd0;
    localparam logic [6:0] REG_VSCROLL  = 7'd1;
    localparam logic [8:0] MIX_FRONT    = 9'd0;
    localparam logic [8:0] MIX_BACKDROP = 9'd1;

    // Sync pulse placement
    localparam int HSYNC_START = 34;
    localparam int HSYNC_END   = 36;
    localparam int VSYNC_LINE  = 25;

    function automatic cpu_target_e addr_target(logic [11:0] addr);
        return cpu_target_e'(addr[11:9]);
    endfunction

endpackage

//--- verilog/video_timer.sv
module video_timer #(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL  = 40,
    parameter int V_ACTIVE = 24,
    parameter int V_TOTAL  = 28
) (
    input  logic               clk,
    input  logic               reset,
    output video_pkg::raster_t raster
);
    import video_pkg::*;

    logic [5:0] x_next;
    logic [4:0] y_next;
    logic       line_end;

    // Full raster word for a given beam position
    function automatic raster_t make_raster(logic [5:0] x, logic [4:0] y);
        raster_t r;
        r.x      = x;
        r.y      = y;
        r.hblank = (x >= 6'(H_ACTIVE));
        r.vblank = (y >= 5'(V_ACTIVE));
        r.hsync  = (x >= 6'(HSYNC_START)) && (x <= 6'(HSYNC_END));
        r.vsync  = (y == 5'(VSYNC_LINE));
        return r;
    endfunction

    // Next beam position
    always_comb begin
        line_end = (raster.x == 6'(H_TOTAL - 1));
        x_next   = line_end ? 6'd0 : raster.x + 6'd1;
        y_next   = raster.y;
        if (line_end) begin
            if (raster.y == 5'(V_TOTAL - 1)) begin
                y_next = 5'd0;
            end else begin
                y_next = raster.y + 5'd1;
            end
        end
    end

    // Flags are registered with the counters so all fields stay aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            raster <= make_raster(6'd0, 5'd0);
        end else begin
            raster <= make_raster(x_next, y_next);
        end
    end

endmodule

//--- verilog/cpu_bus_decoder.sv
module cpu_bus_decoder #(
    parameter int NUM_LAYERS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cpu_req,
    input  video_pkg::cpu_cmd_t   cpu_cmd,
    output logic                  cpu_ack,
    output logic [15:0]           cpu_rdata,
    output video_pkg::cpu_cmd_t   tgt_cmd,
    output logic [NUM_LAYERS-1:0] layer_sel,
    output logic                  pal_sel,
    output logic                  mix_sel,
    input  logic [15:0]           layer_rdata [NUM_LAYERS],
    input  logic [15:0]           mix_rdata
);
    import video_pkg::*;

    bus_state_e  state;
    cpu_target_e target;
    logic        access;

    assign target = addr_target(tgt_cmd.addr);
    assign access = (state == BUS_ACCESS);

    // Four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (cpu_req) begin
                        state <= BUS_ACCESS;
                    end
                end
                BUS_ACCESS: begin
                    state <= BUS_ACK;
                end
                BUS_ACK: begin
                    // Hold ack for as long as the CPU keeps req high
                    if (!cpu_req) begin
                        state <= BUS_IDLE;
                    end
                end
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

    // Command is captured once and held for the whole access
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && cpu_req) begin
            tgt_cmd <= cpu_cmd;
        end
    end

    // One-cycle select strobes
    always_comb begin
        layer_sel = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            layer_sel[i] = access && (int'(target) - int'(TGT_LAYER0) == i);
        end
        pal_sel = access && (target == TGT_PALETTE);
        mix_sel = access && (target == TGT_MIXER);
    end

    assign cpu_ack = (state == BUS_ACK);

    // Target read registers keep their word until the next strobe,
    // so the returned data stays valid for the whole ack phase
    always_comb begin
        cpu_rdata = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (int'(target) - int'(TGT_LAYER0) == i) begin
                cpu_rdata = layer_rdata[i];
            end
        end
        // Palette and mixer share one return path
        if (target == TGT_PALETTE || target == TGT_MIXER) begin
            cpu_rdata = mix_rdata;
        end
    end

endmodule

//--- verilog/tile_layer.sv
module tile_layer (
    input  logic                  clk,
    input  logic                  reset,
    input  video_pkg::raster_t    raster,
    input  logic                  sel,
    input  video_pkg::cpu_cmd_t   cmd,
    output logic [15:0]           rdata,
    output video_pkg::layer_pxl_t pxl
);
    import video_pkg::*;

    // Tile entry is {bank, pattern}, pattern row has bit 7 leftmost
    logic [7:0] tilemap [TILEMAP_DEPTH];
    logic [7:0] pattern [PATTERN_DEPTH];

    logic [6:0] hscroll;
    logic [6:0] vscroll;

    logic [6:0] sx;
    logic [6:0] sy;
    logic [7:0] tile;
    logic [7:0] row_bits;

    logic [7:0] row_q;
    logic [3:0] bank_q;
    logic [2:0] col_q;

    logic       is_map;
    logic       is_pat;
    logic       is_reg;
    logic       wr;

    // Scrolled position wraps on the 128x128 playfield
    assign sx = {1'b0, raster.x} + hscroll;
    assign sy = {2'b0, raster.y} + vscroll;

    assign tile     = tilemap[{sy[6:3], sx[6:3]}];
    assign row_bits = pattern[{tile[3:0], sy[2:0]}];

    // Stage 1: tile and pattern row
    always_ff @(posedge clk) begin
        row_q  <= row_bits;
        bank_q <= tile[7:4];
        col_q  <= sx[2:0];
    end

    // Stage 2: pixel select
    always_ff @(posedge clk) begin
        pxl.opaque <= row_q[3'd7 - col_q];
        pxl.bank   <= bank_q;
    end

    // CPU port
    assign is_map = !cmd.addr[8];
    assign is_pat = cmd.addr[8] && !cmd.addr[7];
    assign is_reg = cmd.addr[8] && cmd.addr[7];
    assign wr     = sel && (cmd.op == CPU_WRITE);

    always_ff @(posedge clk) begin
        if (wr && is_map) begin
            tilemap[cmd.addr[7:0]] <= cmd.wdata[7:0];
        end
        if (wr && is_pat) begin
            pattern[cmd.addr[6:0]] <= cmd.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (wr && is_reg) begin
            if (cmd.addr[6:0] == REG_HSCROLL) begin
                hscroll <= cmd.wdata[6:0];
            end
            if (cmd.addr[6:0] == REG_VSCROLL) begin
                vscroll <= cmd.wdata[6:0];
            end
        end
    end

    // Read data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (sel) begin
            if (is_map) begin
                rdata <= {8'h00, tilemap[cmd.addr[7:0]]};
            end else if (is_pat) begin
                rdata <= {8'h00, pattern[cmd.addr[6:0]]};
            end else if (cmd.addr[6:0] == REG_HSCROLL) begin
                rdata <= {9'h000, hscroll};
            end else if (cmd.addr[6:0] == REG_VSCROLL) begin
                rdata <= {9'h000, vscroll};
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

//--- verilog/color_mixer.sv
module color_mixer #(
    parameter int NUM_LAYERS = 3
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  video_pkg::raster_t                     raster,
    input  video_pkg::layer_pxl_t [NUM_LAYERS-1:0] layer_pxl,
    input  logic                                   pal_sel,
    input  logic                                   mix_sel,
    input  video_pkg::cpu_cmd_t                    cmd,
    output logic [15:0]                            rdata,
    output video_pkg::video_out_t                  video_out
);
    import video_pkg::*;

    // RGB444, red in the top nibble
    logic [11:0] palette [PALETTE_DEPTH];
    logic [1:0]  front_layer;
    logic [5:0]  backdrop;

    logic [5:0]  pal_idx;
    logic [5:0]  pal_idx_q;
    logic [11:0] rgb;
    logic        blank;

    // {hblank, vblank, hsync, vsync} for the three cycles before the output
    logic [3:0]  flags_d [3];

    logic [5:0]  pal_addr;
    logic [8:0]  mix_word;
    logic        wr;

    // Lowest opaque layer first, then the front layer overrides
    always_comb begin
        pal_idx = backdrop;
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            if (layer_pxl[i].opaque) begin
                pal_idx = {2'(i), layer_pxl[i].bank};
            end
        end
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (int'(front_layer) == i && layer_pxl[i].opaque) begin
                pal_idx = {2'(i), layer_pxl[i].bank};
            end
        end
    end

    // Stage 1: priority winner
    always_ff @(posedge clk) begin
        pal_idx_q <= pal_idx;
    end

    // Flags ride along with the two layer stages and the first mixer stage
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                flags_d[i] <= 4'b1100;
            end
        end else begin
            flags_d[0] <= {raster.hblank, raster.vblank, raster.hsync, raster.vsync};
            flags_d[1] <= flags_d[0];
            flags_d[2] <= flags_d[1];
        end
    end

    assign rgb   = palette[pal_idx_q];
    assign blank = flags_d[2][3] || flags_d[2][2];

    // Stage 2: palette lookup, nibbles widened to 8 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            video_out.red    <= '0;
            video_out.green  <= '0;
            video_out.blue   <= '0;
            video_out.hblank <= 1'b1;
            video_out.vblank <= 1'b1;
            video_out.hsync  <= 1'b0;
            video_out.vsync  <= 1'b0;
        end else begin
            video_out.red    <= blank ? 8'h00 : {rgb[11:8], rgb[11:8]};
            video_out.green  <= blank ? 8'h00 : {rgb[7:4], rgb[7:4]};
            video_out.blue   <= blank ? 8'h00 : {rgb[3:0], rgb[3:0]};
            video_out.hblank <= flags_d[2][3];
            video_out.vblank <= flags_d[2][2];
            video_out.hsync  <= flags_d[2][1];
            video_out.vsync  <= flags_d[2][0];
        end
    end

    // CPU port for palette and control registers
    assign pal_addr = cmd.addr[5:0];
    assign mix_word = cmd.addr[8:0];
    assign wr       = (cmd.op == CPU_WRITE);

    always_ff @(posedge clk) begin
        if (pal_sel && wr) begin
            palette[pal_addr] <= cmd.wdata[11:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            front_layer <= '0;
            backdrop    <= '0;
        end else if (mix_sel && wr) begin
            if (mix_word == MIX_FRONT) begin
                front_layer <= cmd.wdata[1:0];
            end
            if (mix_word == MIX_BACKDROP) begin
                backdrop <= cmd.wdata[5:0];
            end
        end
    end

    // Shared read return for both regions
    always_ff @(posedge clk) begin
        if (pal_sel) begin
            rdata <= {4'h0, palette[pal_addr]};
        end else if (mix_sel) begin
            if (mix_word == MIX_FRONT) begin
                rdata <= {14'h0000, front_layer};
            end else if (mix_word == MIX_BACKDROP) begin
                rdata <= {10'h000, backdrop};
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

//--- verilog/video_top.sv
module video_top #(
    parameter int H_ACTIVE   = 32,
    parameter int H_TOTAL    = 40,
    parameter int V_ACTIVE   = 24,
    parameter int V_TOTAL    = 28,
    parameter int NUM_LAYERS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cpu_req,
    input  video_pkg::cpu_cmd_t   cpu_cmd,
    output logic                  cpu_ack,
    output logic [15:0]           cpu_rdata,
    output video_pkg::video_out_t video_out
);
    import video_pkg::*;

    raster_t                     raster;
    cpu_cmd_t                    tgt_cmd;
    logic [NUM_LAYERS-1:0]       layer_sel;
    logic                        pal_sel;
    logic                        mix_sel;
    logic [15:0]                 layer_rdata [NUM_LAYERS];
    logic [15:0]                 mix_rdata;
    layer_pxl_t [NUM_LAYERS-1:0] layer_pxl;

    video_timer #(
        .H_ACTIVE   ( H_ACTIVE      ),
        .H_TOTAL    ( H_TOTAL       ),
        .V_ACTIVE   ( V_ACTIVE      ),
        .V_TOTAL    ( V_TOTAL       )
    ) timer_i (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .raster     ( raster        )
    );

    cpu_bus_decoder #(
        .NUM_LAYERS ( NUM_LAYERS    )
    ) decoder_i (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cpu_req    ( cpu_req       ),
        .cpu_cmd    ( cpu_cmd       ),
        .cpu_ack    ( cpu_ack       ),
        .cpu_rdata  ( cpu_rdata     ),
        .tgt_cmd    ( tgt_cmd       ),
        .layer_sel  ( layer_sel     ),
        .pal_sel    ( pal_sel       ),
        .mix_sel    ( mix_sel       ),
        .layer_rdata( layer_rdata   ),
        .mix_rdata  ( mix_rdata     )
    );

    // One layer per CPU region, index equals priority order
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        tile_layer layer_i (
            .clk    ( clk               ),
            .reset  ( reset             ),
            .raster ( raster            ),
            .sel    ( layer_sel[i]      ),
            .cmd    ( tgt_cmd           ),
            .rdata  ( layer_rdata[i]    ),
            .pxl    ( layer_pxl[i]      )
        );
    end

    color_mixer #(
        .NUM_LAYERS ( NUM_LAYERS    )
    ) mixer_i (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .raster     ( raster        ),
        .layer_pxl  ( layer_pxl     ),
        .pal_sel    ( pal_sel       ),
        .mix_sel    ( mix_sel       ),
        .cmd        ( tgt_cmd       ),
        .rdata      ( mix_rdata     ),
        .video_out  ( video_out     )
    );

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released shortly after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 20);
        reset = 1'b0;
    end

endmodule

//--- testbench/tb_video.sv
module tb_video;
    import video_pkg::*;

    localparam int H_ACTIVE    = 32;
    localparam int H_TOTAL     = 40;
    localparam int V_ACTIVE    = 24;
    localparam int V_TOTAL     = 28;
    localparam int NUM_LAYERS  = 3;
    localparam int FRAME       = H_TOTAL * V_TOTAL;
    localparam int PERIOD      = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int ACK_TIMEOUT = 10;
    localparam int RB_WRITES   = 40;
    localparam int NUM_FRAMES  = 5;
    // Read-back, palette, five layer fills, scroll and mixer setup
    localparam int NUM_ACCESSES = 2 * RB_WRITES + 3 + 64 + 5 * 384 + 12 + 8;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_ACCESSES * 8 + NUM_FRAMES * 2 * FRAME + 20);

    logic       clk;
    logic       reset;
    logic       cpu_req;
    cpu_cmd_t   cpu_cmd;
    logic       cpu_ack;
    logic [15:0] cpu_rdata;
    video_out_t video_out;

    logic [15:0] lfsr;
    int          cycles;

    // Mirror of every RAM and register in the DUT
    logic [7:0]  map_model [NUM_LAYERS][256];
    logic [7:0]  pattern_model [NUM_LAYERS][128];
    logic [6:0]  hscroll_model [NUM_LAYERS];
    logic [6:0]  vscroll_model [NUM_LAYERS];
    logic [11:0] palette_model [64];
    logic [1:0]  front_model;
    logic [5:0]  backdrop_model;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) clock_gen_i (.clk(clk), .reset(reset));

    video_top #(
        .H_ACTIVE   ( H_ACTIVE   ),
        .H_TOTAL    ( H_TOTAL    ),
        .V_ACTIVE   ( V_ACTIVE   ),
        .V_TOTAL    ( V_TOTAL    ),
        .NUM_LAYERS ( NUM_LAYERS )
    ) video_top_i (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cpu_req    ( cpu_req    ),
        .cpu_cmd    ( cpu_cmd    ),
        .cpu_ack    ( cpu_ack    ),
        .cpu_rdata  ( cpu_rdata  ),
        .video_out  ( video_out  )
    );

    // Raster state n is on the timer output after the n-th edge out of reset
    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic out_bit;
        out_bit = s[0];
        s = s >> 1;
        if (out_bit) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic logic [15:0] take_bits(int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return bits;
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic stop_on_error(string msg);
        $display("Error at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_rdata(logic [15:0] got, logic [15:0] exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s returned %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_video(video_out_t got, video_out_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s video_out %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic store_in_model(logic [11:0] addr, logic [15:0] data);
        int tgt;
        tgt = int'(addr[11:9]);
        if (tgt < NUM_LAYERS) begin
            if (!addr[8]) begin
                map_model[tgt][addr[7:0]] = data[7:0];
            end else if (!addr[7]) begin
                pattern_model[tgt][addr[6:0]] = data[7:0];
            end else if (addr[6:0] == 7'd0) begin
                hscroll_model[tgt] = data[6:0];
            end else if (addr[6:0] == 7'd1) begin
                vscroll_model[tgt] = data[6:0];
            end
        end else if (tgt == 6) begin
            palette_model[addr[5:0]] = data[11:0];
        end else if (tgt == 7 && addr[8:0] == 9'd0) begin
            front_model = data[1:0];
        end else if (tgt == 7 && addr[8:0] == 9'd1) begin
            backdrop_model = data[5:0];
        end
    endtask

    function automatic logic [15:0] predict_read(logic [11:0] addr);
        int tgt;
        logic [15:0] v;
        tgt = int'(addr[11:9]);
        v = '0;
        if (tgt < NUM_LAYERS) begin
            if (!addr[8]) begin
                v = {8'h00, map_model[tgt][addr[7:0]]};
            end else if (!addr[7]) begin
                v = {8'h00, pattern_model[tgt][addr[6:0]]};
            end else if (addr[6:0] == 7'd0) begin
                v = {9'h000, hscroll_model[tgt]};
            end else if (addr[6:0] == 7'd1) begin
                v = {9'h000, vscroll_model[tgt]};
            end
        end else if (tgt == 6) begin
            v = {4'h0, palette_model[addr[5:0]]};
        end else if (tgt == 7 && addr[8:0] == 9'd0) begin
            v = {14'h0000, front_model};
        end else if (tgt == 7 && addr[8:0] == 9'd1) begin
            v = {10'h000, backdrop_model};
        end
        return v;
    endfunction

    // Full four-phase cycle, hold keeps req high for extra cycles after ack
    task automatic cpu_access(cpu_op_e op, logic [11:0] addr, logic [15:0] wdata, int hold,
                              output logic [15:0] rdata);
        int waited;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_cmd.op    = op;
        cpu_cmd.addr  = addr;
        cpu_cmd.wdata = wdata;
        cpu_req       = 1'b1;
        // Still inside the cycle that raised req
        @(negedge clk);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_on_error($sformatf("no cpu_ack within %0d cycles", ACK_TIMEOUT));
            end
        end while (cpu_ack !== 1'b1);
        if (waited != 2) begin
            stop_on_error($sformatf("cpu_ack rose %0d cycles after cpu_req, not 2", waited));
        end
        rdata = cpu_rdata;
        repeat (hold) begin
            @(negedge clk);
            if (cpu_ack !== 1'b1) begin
                stop_on_error("cpu_ack dropped while cpu_req was still high");
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req = 1'b0;
        @(negedge clk);
        if (cpu_ack !== 1'b1) begin
            stop_on_error("cpu_ack fell in the same cycle as cpu_req");
        end
        @(negedge clk);
        if (cpu_ack !== 1'b0) begin
            stop_on_error("cpu_ack did not fall one cycle after cpu_req fell");
        end
    endtask

    task automatic write_word(logic [11:0] addr, logic [15:0] data, int hold);
        logic [15:0] unused;
        cpu_access(CPU_WRITE, addr, data, hold, unused);
        store_in_model(addr, data);
    endtask

    task automatic read_back(logic [11:0] addr, int hold);
        logic [15:0] got;
        cpu_access(CPU_READ, addr, 16'h0000, hold, got);
        check_rdata(got, predict_read(addr), $sformatf("read of address %h", addr));
    endtask

    task automatic readback_test();
        logic [11:0] addrs [$];
        logic [11:0] addr;
        int          region;
        int          kind;
        for (int n = 0; n < RB_WRITES; n++) begin
            region = int'(take_bits(3)) % 5;
            kind   = int'(take_bits(2));
            if (region < NUM_LAYERS) begin
                if (kind < 2) begin
                    addr = {3'(region), 1'b0, 8'(take_bits(8))};
                end else if (kind == 2) begin
                    addr = {3'(region), 2'b10, 7'(take_bits(7))};
                end else begin
                    addr = {3'(region), 2'b11, 6'd0, 1'(take_bits(1))};
                end
            end else if (region == 3) begin
                addr = {TGT_PALETTE, 3'b000, 6'(take_bits(6))};
            end else begin
                addr = {TGT_MIXER, 8'h00, 1'(take_bits(1))};
            end
            write_word(addr, take_bits(16), int'(take_bits(2)));
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            read_back(addrs[i], int'(take_bits(2)));
        end
        // Unused regions read as zero
        for (int t = 3; t < 6; t++) begin
            read_back({3'(t), 9'(take_bits(9))}, 0);
        end
    endtask

    task automatic load_layer(int l, logic with_pixels);
        logic [15:0] row;
        for (int i = 0; i < 256; i++) begin
            write_word({3'(l), 1'b0, 8'(i)}, take_bits(8), 0);
        end
        for (int i = 0; i < 128; i++) begin
            row = '0;
            if (with_pixels) begin
                row = take_bits(8);
            end
            write_word({3'(l), 2'b10, 7'(i)}, row, 0);
        end
    endtask

    task automatic set_scroll(int l, logic [6:0] h, logic [6:0] v);
        write_word({3'(l), 2'b11, 7'd0}, {9'h000, h}, 0);
        write_word({3'(l), 2'b11, 7'd1}, {9'h000, v}, 0);
    endtask

    // Expected output for linear raster position p
    function automatic video_out_t expected_video(int p);
        video_out_t            v;
        int                    x;
        int                    y;
        int                    sx;
        int                    sy;
        int                    win;
        logic [7:0]            tile;
        logic [7:0]            row;
        logic [NUM_LAYERS-1:0] opaque;
        logic [3:0]            bank [NUM_LAYERS];
        logic [5:0]            idx;
        logic [11:0]           rgb;
        x = p % H_TOTAL;
        y = p / H_TOTAL;
        v = '0;
        v.hblank = (x >= H_ACTIVE);
        v.vblank = (y >= V_ACTIVE);
        v.hsync  = (x >= 34) && (x <= 36);
        v.vsync  = (y == 25);
        for (int l = 0; l < NUM_LAYERS; l++) begin
            sx = (x + int'(hscroll_model[l])) % 128;
            sy = (y + int'(vscroll_model[l])) % 128;
            tile = map_model[l][(sy / 8) * 16 + sx / 8];
            row = pattern_model[l][int'(tile[3:0]) * 8 + sy % 8];
            opaque[l] = row[7 - sx % 8];
            bank[l] = tile[7:4];
        end
        win = -1;
        if (int'(front_model) < NUM_LAYERS) begin
            if (opaque[front_model]) begin
                win = int'(front_model);
            end
        end
        for (int l = 0; l < NUM_LAYERS; l++) begin
            if (win < 0 && opaque[l]) begin
                win = l;
            end
        end
        if (win < 0) begin
            idx = backdrop_model;
        end else begin
            idx = {2'(win), bank[win]};
        end
        if (!v.hblank && !v.vblank) begin
            rgb = palette_model[idx];
            v.red   = {rgb[11:8], rgb[11:8]};
            v.green = {rgb[7:4], rgb[7:4]};
            v.blue  = {rgb[3:0], rgb[3:0]};
        end
        return v;
    endfunction

    // Output lags the raster by 4 cycles
    task automatic compare_frame(string what);
        int p;
        repeat (8) @(negedge clk);
        while ((cycles - 4) % FRAME != 0) begin
            @(negedge clk);
        end
        for (int k = 0; k < FRAME; k++) begin
            p = (cycles - 4) % FRAME;
            check_video(video_out, expected_video(p),
                        $sformatf("%s at x %0d y %0d", what, p % H_TOTAL, p / H_TOTAL));
            @(negedge clk);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        video_out_t reset_out;
        cpu_req  = 1'b0;
        cpu_cmd  = '0;
        lfsr     = 16'd49;
        reset_out = '0;
        reset_out.hblank = 1'b1;
        reset_out.vblank = 1'b1;

        @(negedge clk);
        if (cpu_ack !== 1'b0) begin
            stop_on_error("cpu_ack is high during reset");
        end
        check_video(video_out, reset_out, "during reset");
        wait (reset == 1'b0);
        // First edge out of reset still shows the blanked pipeline
        @(posedge clk);
        @(negedge clk);
        if (cpu_ack !== 1'b0) begin
            stop_on_error("cpu_ack is high after reset");
        end
        check_video(video_out, reset_out, "after reset");

        readback_test();

        // Layer 0 alone over the backdrop, no scroll
        for (int i = 0; i < 64; i++) begin
            write_word({TGT_PALETTE, 3'b000, 6'(i)}, take_bits(12), 0);
        end
        load_layer(0, 1'b1);
        load_layer(1, 1'b0);
        load_layer(2, 1'b0);
        for (int l = 0; l < NUM_LAYERS; l++) begin
            set_scroll(l, 7'd0, 7'd0);
        end
        write_word({TGT_MIXER, 9'd0}, 16'd0, 0);
        write_word({TGT_MIXER, 9'd1}, take_bits(6), 0);
        compare_frame("single layer");

        // All layers populated and scrolled
        load_layer(1, 1'b1);
        load_layer(2, 1'b1);
        for (int l = 0; l < NUM_LAYERS; l++) begin
            set_scroll(l, 7'(take_bits(7)), 7'(take_bits(7)));
        end
        compare_frame("scrolled layers");

        for (int f = 1; f < 4; f++) begin
            write_word({TGT_MIXER, 9'd0}, 16'(f), 0);
            write_word({TGT_MIXER, 9'd1}, take_bits(6), 0);
            compare_frame($sformatf("front layer %0d", f));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- files.f
verilog/video_pkg.sv
verilog/video_timer.sv
verilog/cpu_bus_decoder.sv
verilog/tile_layer.sv
verilog/color_mixer.sv
verilog/video_top.sv
testbench/tb_clock_gen.sv
testbench/tb_video.sv

//--- Bender.yml
package:
  name: tile_video

sources:
  - verilog/video_pkg.sv
  - verilog/video_timer.sv
  - verilog/cpu_bus_decoder.sv
  - verilog/tile_layer.sv
  - verilog/color_mixer.sv
  - verilog/video_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_video.sv
